// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction word
`define CPU_WORD_WIDTH 16

// program memory addressing
`define CPU_ADDR_WIDTH 8
`define CPU_MEM_DEPTH 256

// ax, bx, cx, dx
`define CPU_REG_COUNT 4

`endif

// File: design/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef enum logic [15:0] {
		opNop  = 16'h0000,
		opMov3 = 16'h0007, // reg <- reg
		opMov4 = 16'h0008, // reg <- immediate
		opOut  = 16'h000A,
		opAdd  = 16'h000C,
		opAdc  = 16'h000D,
		opSub  = 16'h000E,
		opCmp  = 16'h0014,
		opAnd  = 16'h0015,
		opNot  = 16'h0017,
		opOr   = 16'h0018,
		opShl  = 16'h0019,
		opShr  = 16'h001A,
		opXor  = 16'h001B,
		opJmp  = 16'h0020,
		opJc   = 16'h0021,
		opJz   = 16'h0023,
		opJnz  = 16'h0024,
		opIn   = 16'h0028
	} opcode_t;

	typedef enum logic [1:0] {
		regAx = 2'b00,
		regBx = 2'b01,
		regCx = 2'b10,
		regDx = 2'b11
	} regSel_t;

	typedef enum logic [3:0] {
		aluAdd, aluAdc, aluSub, aluCmp,
		aluAnd, aluOr, aluXor, aluNot,
		aluShl, aluShr
	} aluOp_t;

endpackage

`default_nettype wire

// File: design/datapathPkg.sv
`default_nettype none

`include "cpu_config.svh"

package datapathPkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
	typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;

	// bit positions inside aluFlags_t
	localparam int flagCarry = 2;
	localparam int flagZero = 1;
	localparam int flagOverflow = 0;
	typedef logic [2:0] aluFlags_t;

	typedef enum logic {
		execute, // fetch, decode, single-cycle ops, ALU issue
		aluWait // ALU result writeback
	} seqState_t;

endpackage

`default_nettype wire

// File: design/cpuInterfaces.sv
`timescale 1ns/10ps
`default_nettype none

interface aluBus;
	datapathPkg::word_t opA;
	datapathPkg::word_t opB;
	isaPkg::aluOp_t op;
	logic start; // one-cycle issue pulse
	datapathPkg::word_t result; // valid the cycle after start
	datapathPkg::aluFlags_t flags;

	modport initiator (output opA, output opB, output op, output start,
		input result, input flags);
	modport target (input opA, input opB, input op, input start,
		output result, output flags);
endinterface

interface regBus;
	isaPkg::regSel_t srcSelA;
	isaPkg::regSel_t srcSelB;
	datapathPkg::word_t readA; // combinational
	datapathPkg::word_t readB;
	logic writeEnable;
	isaPkg::regSel_t writeSel;
	datapathPkg::word_t writeData;

	modport initiator (output srcSelA, output srcSelB, input readA, input readB,
		output writeEnable, output writeSel, output writeData);
	modport target (input srcSelA, input srcSelB, output readA, output readB,
		input writeEnable, input writeSel, input writeData);
endinterface

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module alu (
	input wire clk,
	input wire reset,
	aluBus.target bus,
	input wire carryIn
);
	localparam int W = `CPU_WORD_WIDTH;

	datapathPkg::word_t res;
	datapathPkg::aluFlags_t newFlags;
	logic carryOut; // borrow for sub and cmp
	logic ovf;
	logic cin;

	assign cin = (bus.op == isaPkg::aluAdc) ? carryIn : 1'b0;

	always_comb begin
		res = '0;
		carryOut = 1'b0;
		ovf = 1'b0;
		case (bus.op)
			isaPkg::aluAdd, isaPkg::aluAdc: begin
				{carryOut, res} = {1'b0, bus.opA} + {1'b0, bus.opB} + {{W{1'b0}}, cin};
				ovf = (bus.opA[W-1] == bus.opB[W-1]) && (res[W-1] != bus.opA[W-1]);
			end
			isaPkg::aluSub, isaPkg::aluCmp: begin
				{carryOut, res} = {1'b0, bus.opA} - {1'b0, bus.opB};
				ovf = (bus.opA[W-1] != bus.opB[W-1]) && (res[W-1] != bus.opA[W-1]);
			end
			isaPkg::aluAnd: res = bus.opA & bus.opB;
			isaPkg::aluOr: res = bus.opA | bus.opB;
			isaPkg::aluXor: res = bus.opA ^ bus.opB;
			isaPkg::aluNot: res = ~bus.opA;
			isaPkg::aluShl: {carryOut, res} = {bus.opA, 1'b0}; // msb drops into carry
			isaPkg::aluShr: {res, carryOut} = {1'b0, bus.opA};
			default: res = '0;
		endcase
		newFlags[datapathPkg::flagCarry] = carryOut;
		newFlags[datapathPkg::flagZero] = (res == '0);
		newFlags[datapathPkg::flagOverflow] = ovf;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			bus.result <= '0;
			bus.flags <= '0;
		end else if (bus.start) begin
			bus.result <= res; // held until next start
			bus.flags <= newFlags;
		end
	end
endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module registerFile (
	input wire clk,
	input wire reset,
	regBus.target regs,
	output datapathPkg::word_t bxValue,
	output datapathPkg::word_t dxValue
);
	datapathPkg::word_t regFile [`CPU_REG_COUNT]; // indexed by regSel_t

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (regs.writeEnable) begin
			regFile[regs.writeSel] <= regs.writeData;
		end
	end

	// two general read ports
	assign regs.readA = regFile[regs.srcSelA];
	assign regs.readB = regFile[regs.srcSelB];

	// fixed taps, bx is the port base and dx the port data
	assign bxValue = regFile[isaPkg::regBx];
	assign dxValue = regFile[isaPkg::regDx];
endmodule

`default_nettype wire

// File: design/programMemory.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module programMemory (
	input wire clk,
	input wire progWrite,
	input wire datapathPkg::addr_t progAddr,
	input wire datapathPkg::word_t progData,
	input wire datapathPkg::addr_t pc,
	output datapathPkg::word_t word0,
	output datapathPkg::word_t word1,
	output datapathPkg::word_t word2
);
	datapathPkg::word_t mem [`CPU_MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (progWrite) begin
			mem[progAddr] <= progData;
		end
	end

	// opcode plus two operand words, addresses wrap at the top
	assign word0 = mem[pc];
	assign word1 = mem[pc + datapathPkg::addr_t'(1)];
	assign word2 = mem[pc + datapathPkg::addr_t'(2)];
endmodule

`default_nettype wire

// File: design/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module controlUnit (
	input wire clk,
	input wire reset,
	output datapathPkg::addr_t pc,
	input wire datapathPkg::word_t word0,
	input wire datapathPkg::word_t word1,
	input wire datapathPkg::word_t word2,
	input wire datapathPkg::word_t inPort,
	input wire datapathPkg::word_t bxValue,
	input wire datapathPkg::word_t dxValue,
	aluBus.initiator aluPort,
	regBus.initiator regs,
	output logic flag,
	output logic carry
);
	isaPkg::opcode_t opcode;
	isaPkg::regSel_t firstSel; // destination and first operand
	isaPkg::regSel_t secondSel; // source
	isaPkg::aluOp_t aluOp;
	datapathPkg::seqState_t state;
	datapathPkg::aluFlags_t flags;
	datapathPkg::addr_t length;
	datapathPkg::addr_t pcNext;
	datapathPkg::word_t srcValue;
	logic isArith; // fixed dx, ax operands
	logic isBinary;
	logic isUnary;
	logic takeJump;
	logic issue;

	assign opcode = isaPkg::opcode_t'(word0);
	assign firstSel = isaPkg::regSel_t'(word1[3:2]);
	assign secondSel = isaPkg::regSel_t'(word1[1:0]);
	assign carry = flags[datapathPkg::flagCarry];

	always_comb begin
		isArith = 1'b0;
		isBinary = 1'b0;
		isUnary = 1'b0;
		takeJump = 1'b0;
		aluOp = isaPkg::aluAdd;
		length = datapathPkg::addr_t'(1);
		case (opcode)
			isaPkg::opAdd: isArith = 1'b1;
			isaPkg::opAdc: begin isArith = 1'b1; aluOp = isaPkg::aluAdc; end
			isaPkg::opSub: begin isArith = 1'b1; aluOp = isaPkg::aluSub; end
			isaPkg::opCmp: begin isArith = 1'b1; aluOp = isaPkg::aluCmp; end
			isaPkg::opAnd: begin isBinary = 1'b1; aluOp = isaPkg::aluAnd; end
			isaPkg::opOr: begin isBinary = 1'b1; aluOp = isaPkg::aluOr; end
			isaPkg::opXor: begin isBinary = 1'b1; aluOp = isaPkg::aluXor; end
			isaPkg::opNot: begin isUnary = 1'b1; aluOp = isaPkg::aluNot; end
			isaPkg::opShl: begin isUnary = 1'b1; aluOp = isaPkg::aluShl; end
			isaPkg::opShr: begin isUnary = 1'b1; aluOp = isaPkg::aluShr; end
			isaPkg::opMov4: length = datapathPkg::addr_t'(3);
			isaPkg::opJmp: takeJump = 1'b1;
			isaPkg::opJc: takeJump = flags[datapathPkg::flagCarry];
			isaPkg::opJz: takeJump = flags[datapathPkg::flagZero];
			isaPkg::opJnz: takeJump = !flags[datapathPkg::flagZero];
			default: ; // unknown opcodes run as a one-word nop
		endcase
		if (isBinary || isUnary || opcode == isaPkg::opMov3 || opcode == isaPkg::opJmp ||
			opcode == isaPkg::opJc || opcode == isaPkg::opJz || opcode == isaPkg::opJnz) begin
			length = datapathPkg::addr_t'(2);
		end
	end

	assign srcValue = regs.readB; // register picked by word1 bits 1:0

	assign regs.srcSelA = isArith ? isaPkg::regAx : firstSel;
	assign regs.srcSelB = secondSel;

	assign issue = (state == datapathPkg::execute) && (isArith || isBinary || isUnary);
	assign aluPort.start = issue;
	assign aluPort.op = aluOp;
	assign aluPort.opA = isArith ? dxValue : (isUnary ? srcValue : regs.readA);
	assign aluPort.opB = isArith ? regs.readA : srcValue;

	always_comb begin
		regs.writeEnable = 1'b0;
		regs.writeSel = firstSel;
		regs.writeData = srcValue;
		if (state == datapathPkg::execute) begin
			case (opcode)
				isaPkg::opMov3: regs.writeEnable = 1'b1;
				isaPkg::opMov4: begin
					regs.writeEnable = 1'b1;
					regs.writeSel = secondSel;
					regs.writeData = word2;
				end
				isaPkg::opIn: begin
					regs.writeEnable = 1'b1;
					regs.writeSel = isaPkg::regDx;
					regs.writeData = inPort;
				end
				default: ;
			endcase
		end else begin
			regs.writeData = aluPort.result;
			if (isArith) begin
				regs.writeEnable = (opcode != isaPkg::opCmp); // cmp only touches flags
				regs.writeSel = isaPkg::regAx;
			end else if (isUnary) begin
				regs.writeEnable = 1'b1;
				regs.writeSel = secondSel;
			end else begin
				regs.writeEnable = isBinary;
			end
		end
	end

	always_comb begin
		pcNext = pc + length;
		if (issue) begin
			pcNext = pc; // hold while the ALU works
		end else if (state == datapathPkg::execute && takeJump) begin
			pcNext = word1[`CPU_ADDR_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			state <= datapathPkg::execute;
			flags <= '0;
			flag <= 1'b0;
		end else begin
			pc <= pcNext;
			flag <= (state == datapathPkg::execute) && (opcode == isaPkg::opOut);
			if (state == datapathPkg::execute) begin
				if (issue) begin
					state <= datapathPkg::aluWait;
				end
			end else begin
				state <= datapathPkg::execute;
				if (isArith) begin
					flags <= aluPort.flags; // logic ops keep the flags
				end
			end
		end
	end
endmodule

`default_nettype wire

// File: design/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
	input wire clk,
	input wire reset,
	input wire datapathPkg::word_t inPort,
	input wire progWrite,
	input wire datapathPkg::addr_t progAddr,
	input wire datapathPkg::word_t progData,
	output datapathPkg::word_t base,
	output datapathPkg::word_t data,
	output logic flag
);
	datapathPkg::addr_t pc;
	datapathPkg::word_t word0;
	datapathPkg::word_t word1;
	datapathPkg::word_t word2;
	datapathPkg::word_t bxValue;
	datapathPkg::word_t dxValue;
	logic carry;

	aluBus aluLink ();
	regBus regLink ();

	programMemory i_memory (
		.clk(clk),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.pc(pc),
		.word0(word0),
		.word1(word1),
		.word2(word2)
	);

	registerFile i_regs (
		.clk(clk),
		.reset(reset),
		.regs(regLink.target),
		.bxValue(bxValue),
		.dxValue(dxValue)
	);

	alu i_alu (
		.clk(clk),
		.reset(reset),
		.bus(aluLink.target),
		.carryIn(carry) // adc
	);

	controlUnit i_control (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.word0(word0),
		.word1(word1),
		.word2(word2),
		.inPort(inPort),
		.bxValue(bxValue),
		.dxValue(dxValue),
		.aluPort(aluLink.initiator),
		.regs(regLink.initiator),
		.flag(flag),
		.carry(carry)
	);

	assign base = bxValue; // port address
	assign data = dxValue;
endmodule

`default_nettype wire

// File: test/cpuTests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// program builders, each keeps the register and flag model in step
task automatic newProgram(input string name);
	testName = name;
	progLen = 0;
	for (int i = 0; i < 4; i++) begin
		model[i] = '0;
	end
	modelCarry = 1'b0;
	modelZero = 1'b0;
	inValue = '0;
	expBase.delete();
	expData.delete();
endtask

task automatic appendWord(input datapathPkg::word_t w);
	progImage[progLen] = w;
	progLen++;
endtask

task automatic loadImmediate(input isaPkg::regSel_t r, input datapathPkg::word_t value);
	appendWord(isaPkg::opMov4);
	appendWord({14'h0, r});
	appendWord(value);
	model[r] = value;
endtask

task automatic copyRegister(input isaPkg::regSel_t dst, input isaPkg::regSel_t src);
	appendWord(isaPkg::opMov3);
	appendWord({12'h0, dst, src});
	model[dst] = model[src];
endtask

task automatic outputRegs();
	appendWord(isaPkg::opOut);
	expBase.push_back(model[isaPkg::regBx]);
	expData.push_back(model[isaPkg::regDx]);
endtask

task automatic inputToDx();
	appendWord(isaPkg::opIn);
	model[isaPkg::regDx] = inValue;
endtask

// a is dx and b is ax
task automatic arithmeticOp(input isaPkg::opcode_t op);
	int a;
	int b;
	int total;
	datapathPkg::word_t res;
	a = int'(model[isaPkg::regDx]);
	b = int'(model[isaPkg::regAx]);
	if (op == isaPkg::opSub || op == isaPkg::opCmp) begin
		total = a - b;
		modelCarry = (a < b); // borrow
	end else begin
		total = a + b + ((op == isaPkg::opAdc && modelCarry) ? 1 : 0);
		modelCarry = (total > 65535);
	end
	res = datapathPkg::word_t'(total);
	modelZero = (res == '0);
	if (op != isaPkg::opCmp) begin
		model[isaPkg::regAx] = res;
	end
	appendWord(op);
endtask

task automatic logicOp(input isaPkg::opcode_t op, input isaPkg::regSel_t dst,
	input isaPkg::regSel_t src);
	appendWord(op);
	appendWord({12'h0, dst, src});
	case (op)
		isaPkg::opAnd: model[dst] = model[dst] & model[src];
		isaPkg::opOr: model[dst] = model[dst] | model[src];
		default: model[dst] = model[dst] ^ model[src];
	endcase
endtask

task automatic unaryOp(input isaPkg::opcode_t op, input isaPkg::regSel_t r);
	appendWord(op);
	appendWord({14'h0, r});
	case (op)
		isaPkg::opNot: model[r] = ~model[r];
		isaPkg::opShl: model[r] = model[r] << 1;
		default: model[r] = model[r] >> 1;
	endcase
endtask

// bx ends up holding the marker of the path the jump picks
task automatic branchToMarker(input isaPkg::opcode_t op, input datapathPkg::word_t fallMarker,
	input datapathPkg::word_t takenMarker);
	int jumpAt;
	int joinAt;
	logic taken;
	case (op)
		isaPkg::opJc: taken = modelCarry;
		isaPkg::opJz: taken = modelZero;
		default: taken = !modelZero;
	endcase
	jumpAt = progLen;
	appendWord(op);
	appendWord('0); // target filled in below
	loadImmediate(isaPkg::regBx, fallMarker);
	joinAt = progLen;
	appendWord(isaPkg::opJmp);
	appendWord('0);
	progImage[jumpAt + 1] = datapathPkg::word_t'(progLen);
	loadImmediate(isaPkg::regBx, takenMarker);
	progImage[joinAt + 1] = datapathPkg::word_t'(progLen);
	model[isaPkg::regBx] = taken ? takenMarker : fallMarker;
endtask

task automatic haltHere();
	appendWord(isaPkg::opJmp);
	appendWord(datapathPkg::word_t'(progLen - 1)); // jump to itself
endtask

task automatic addSubBlock(input isaPkg::opcode_t op, input datapathPkg::word_t a,
	input datapathPkg::word_t b);
	loadImmediate(isaPkg::regDx, a);
	loadImmediate(isaPkg::regAx, b);
	arithmeticOp(op);
	branchToMarker(isaPkg::opJc, 16'h00C0, 16'h00C1);
	copyRegister(isaPkg::regDx, isaPkg::regAx);
	outputRegs();
endtask

task automatic binaryBlock(input isaPkg::opcode_t op, input isaPkg::regSel_t dst,
	input isaPkg::regSel_t src);
	loadImmediate(dst, randomWord());
	loadImmediate(src, randomWord());
	logicOp(op, dst, src);
	copyRegister(isaPkg::regDx, dst);
	outputRegs();
endtask

task automatic unaryBlock(input isaPkg::opcode_t op, input isaPkg::regSel_t r);
	loadImmediate(r, randomWord());
	unaryOp(op, r);
	copyRegister(isaPkg::regDx, r);
	outputRegs();
endtask

task automatic resetIdleTest();
	newProgram("reset");
	appendWord(isaPkg::opNop);
	appendWord(isaPkg::opNop);
	appendWord(16'h0003); // undefined, runs as a nop
	outputRegs();
	haltHere();
	runProgram(1'b1);
endtask

task automatic moveTest();
	newProgram("moves");
	loadImmediate(isaPkg::regBx, randomWord());
	loadImmediate(isaPkg::regDx, randomWord());
	outputRegs();
	loadImmediate(isaPkg::regCx, randomWord());
	copyRegister(isaPkg::regDx, isaPkg::regCx);
	outputRegs();
	loadImmediate(isaPkg::regAx, randomWord());
	copyRegister(isaPkg::regBx, isaPkg::regAx);
	copyRegister(isaPkg::regDx, isaPkg::regBx);
	outputRegs();
	haltHere();
	runProgram(1'b0);
endtask

task automatic arithTest();
	newProgram("arith");
	addSubBlock(isaPkg::opAdd, 16'hFFFF, 16'h0001); // wraps to zero with carry
	addSubBlock(isaPkg::opAdc, randomWord(), randomWord());
	addSubBlock(isaPkg::opSub, 16'h0001, 16'h0002); // borrow
	for (int i = 0; i < 2; i++) begin
		addSubBlock(isaPkg::opAdd, randomWord(), randomWord());
		addSubBlock(isaPkg::opAdc, randomWord(), randomWord());
		addSubBlock(isaPkg::opSub, randomWord(), randomWord());
	end
	haltHere();
	runProgram(1'b0);
endtask

task automatic logicTest();
	newProgram("logic");
	binaryBlock(isaPkg::opAnd, isaPkg::regAx, isaPkg::regBx);
	binaryBlock(isaPkg::opAnd, isaPkg::regDx, isaPkg::regCx);
	binaryBlock(isaPkg::opOr, isaPkg::regCx, isaPkg::regAx);
	binaryBlock(isaPkg::opOr, isaPkg::regBx, isaPkg::regDx);
	binaryBlock(isaPkg::opXor, isaPkg::regAx, isaPkg::regCx);
	binaryBlock(isaPkg::opXor, isaPkg::regDx, isaPkg::regBx);
	unaryBlock(isaPkg::opNot, isaPkg::regAx);
	unaryBlock(isaPkg::opNot, isaPkg::regCx);
	unaryBlock(isaPkg::opShl, isaPkg::regBx);
	unaryBlock(isaPkg::opShl, isaPkg::regDx);
	unaryBlock(isaPkg::opShr, isaPkg::regCx);
	unaryBlock(isaPkg::opShr, isaPkg::regAx);
	haltHere();
	runProgram(1'b0);
endtask

task automatic compareInputTest();
	datapathPkg::word_t v;
	newProgram("compare");
	v = randomWord();
	inValue = randomWord();
	loadImmediate(isaPkg::regDx, v);
	loadImmediate(isaPkg::regAx, v);
	arithmeticOp(isaPkg::opCmp); // equal
	branchToMarker(isaPkg::opJz, 16'h0E00, 16'h0E01);
	outputRegs();
	branchToMarker(isaPkg::opJnz, 16'h0E10, 16'h0E11);
	outputRegs();
	loadImmediate(isaPkg::regAx, v ^ 16'h0100);
	arithmeticOp(isaPkg::opCmp); // unequal
	branchToMarker(isaPkg::opJz, 16'h0E20, 16'h0E21);
	outputRegs();
	branchToMarker(isaPkg::opJnz, 16'h0E30, 16'h0E31);
	outputRegs();
	inputToDx();
	outputRegs();
	haltHere();
	runProgram(1'b0);
endtask

`endif

// File: test/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module cpuTb;
	localparam int cycleLimit = 3000; // about five tests of 200 cycles, with margin
	localparam int runLimit = 200; // cycles per program after reset
	localparam int quietCycles = 12; // watch for extra pulses

	logic clk = 1'b0;
	logic reset;
	logic progWrite;
	datapathPkg::addr_t progAddr;
	datapathPkg::word_t progData;
	datapathPkg::word_t inPort;
	datapathPkg::word_t base;
	datapathPkg::word_t data;
	logic flag;

	datapathPkg::word_t progImage [`CPU_MEM_DEPTH];
	int progLen;
	datapathPkg::word_t model [4]; // expected ax to dx
	logic modelCarry;
	logic modelZero;
	datapathPkg::word_t inValue; // level on inPort while a program runs
	datapathPkg::word_t expBase [$];
	datapathPkg::word_t expData [$];
	logic [31:0] rngState = 32'h80c4;
	string testName;
	int cycleCount = 0;
	int valueErrors = 0;
	int pulseErrors = 0;

	cpuTop i_dut (
		.clk(clk),
		.reset(reset),
		.inPort(inPort),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.base(base),
		.data(data),
		.flag(flag)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("run stopped at the limit of %0d clock cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic datapathPkg::word_t randomWord();
		rngState = xorshift32(rngState);
		return rngState[15:0];
	endfunction

	task automatic checkWord(input string signal, input datapathPkg::word_t actual,
		input datapathPkg::word_t expected);
		if (actual !== expected) begin
			valueErrors++;
			$display("ERR %s: got %h, expected %h (%s test, cycle %0d)", signal, actual,
				expected, testName, cycleCount);
		end
	endtask

	// load the image under reset, release it, then match OUT pulses in order
	task automatic runProgram(input logic idleCheck);
		int got;
		int waited;
		@(negedge clk);
		reset = 1'b0;
		inPort = inValue;
		for (int i = 0; i < progLen; i++) begin
			progWrite = 1'b1;
			progAddr = datapathPkg::addr_t'(i);
			progData = progImage[i];
			@(negedge clk);
		end
		progWrite = 1'b0;
		repeat (8) begin
			@(negedge clk);
			if (flag !== 1'b0) begin
				valueErrors++;
				$display("ERR flag: got %h, expected 0 during reset (%s test)", flag, testName);
			end
			checkWord("base", base, '0);
			checkWord("data", data, '0);
		end
		reset = 1'b1;
		got = 0;
		waited = 0;
		while (got < expData.size() && waited < runLimit) begin
			@(negedge clk);
			waited++;
			if (flag === 1'b1) begin
				checkWord("base", base, expBase[got]);
				checkWord("data", data, expData[got]);
				got++;
			end else if (idleCheck && got == 0) begin
				checkWord("base", base, '0); // nothing written yet
				checkWord("data", data, '0);
			end
		end
		if (got < expData.size()) begin
			pulseErrors++;
			$display("%s test: only %0d of %0d OUT pulses seen within %0d cycles", testName,
				got, expData.size(), runLimit);
		end
		repeat (quietCycles) begin
			@(negedge clk);
			if (flag === 1'b1) begin
				pulseErrors++;
				$display("%s test: unexpected OUT pulse after the last expected one", testName);
			end
		end
	endtask

	`include "cpuTests.svh"

	initial begin
		reset = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		inPort = '0;
		resetIdleTest();
		moveTest();
		arithTest();
		logicTest();
		compareInputTest();
		$display("errors: %0d wrong values, %0d missing or extra OUT pulses", valueErrors,
			pulseErrors);
		if (valueErrors == 0 && pulseErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: build.f
+incdir+design
+incdir+test
design/isaPkg.sv
design/datapathPkg.sv
design/cpuInterfaces.sv
design/alu.sv
design/registerFile.sv
design/programMemory.sv
design/controlUnit.sv
design/cpuTop.sv
test/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module cpuTb -f build.f -o cpuSim &&
	./obj_dir/cpuSim | tee sim.log
grep -q "Test completed successfully" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
